//--- logic/isa_pkg.sv
package isa_pkg;

    // register file geometry
    localparam int REG_COUNT = 32;
    localparam int PTR_WIDTH = 5;

    // instruction word fields
    localparam int IMM_WIDTH = 13;

    // inter-stage operand width, only the low ENTRY_WIDTH bits carry data
    localparam int OPERAND_WIDTH = 64;

    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_OR  = 4'd3,
        OP_XOR = 4'd4,
        OP_SHL = 4'd5,
        OP_SHR = 4'd6,
        OP_LI  = 4'd7
    } opcode_t;

    // 32-bit instruction word, op in the top nibble
    typedef struct packed {
        opcode_t                op;
        logic [PTR_WIDTH-1:0]   rd;
        logic [PTR_WIDTH-1:0]   rs1;
        logic [PTR_WIDTH-1:0]   rs2;
        logic [IMM_WIDTH-1:0]   imm;
    } instr_t;

    // issue -> execute
    typedef struct packed {
        logic                       valid;
        opcode_t                    op;
        logic [PTR_WIDTH-1:0]       rd;
        logic [OPERAND_WIDTH-1:0]   a;
        logic [OPERAND_WIDTH-1:0]   b;
    } exec_bundle_t;

    // execute -> writeback, also used for forwarding
    typedef struct packed {
        logic                       valid;
        logic [PTR_WIDTH-1:0]       rd;
        logic [OPERAND_WIDTH-1:0]   result;
    } wb_bundle_t;

endpackage

//--- logic/bus_pkg.sv
package bus_pkg;

    localparam int ADR_WIDTH  = 7;
    localparam int DATA_WIDTH = 32;

    // address map
    // adr[6] == 0 -> instruction port
    // adr[6] == 1 -> register window, register picked by adr[4:0]
    localparam int REG_WINDOW_BIT = 6;

    // master to slave
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [ADR_WIDTH-1:0]   adr;
        logic [DATA_WIDTH-1:0]  dat_w;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                   ack;
        logic [DATA_WIDTH-1:0]  dat_r;
    } wb_rsp_t;

endpackage

//--- logic/reg_file.sv
module reg_file #(
    parameter int ENTRY_WIDTH   = 32,
    parameter int REG_COUNT     = 32,
    parameter int N_READ_PORTS  = 3,
    parameter int N_WRITE_PORTS = 2,
    localparam int PTR_WIDTH    = $clog2(REG_COUNT)
) (
    input  logic                                        clk,
    input  logic                                        init,

    input  logic [N_READ_PORTS-1:0][PTR_WIDTH-1:0]      rd_addr,
    output logic [N_READ_PORTS-1:0][ENTRY_WIDTH-1:0]    rd_data,

    input  logic [N_WRITE_PORTS-1:0]                    wr_en,
    input  logic [N_WRITE_PORTS-1:0][PTR_WIDTH-1:0]     wr_addr,
    input  logic [N_WRITE_PORTS-1:0][ENTRY_WIDTH-1:0]   wr_data
);

    logic [REG_COUNT-1:0][ENTRY_WIDTH-1:0] regs;

    // combinational read ports
    for (genvar r = 0; r < N_READ_PORTS; r++) begin : g_read
        assign rd_data[r] = regs[rd_addr[r]];
    end

    // later ports override earlier ones on a shared address
    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            regs <= '0;
        end else begin
            for (int w = 0; w < N_WRITE_PORTS; w++) begin
                if (wr_en[w]) begin
                    regs[wr_addr[w]] <= wr_data[w];
                end
            end
        end
    end

endmodule

//--- logic/wb_host_port.sv
module wb_host_port
    import isa_pkg::*;
    import bus_pkg::*;
#(
    parameter int ENTRY_WIDTH = 32
) (
    input  logic                    clk,
    input  logic                    init,

    input  wb_req_t                 bus_req,
    output wb_rsp_t                 bus_rsp,

    // instruction stream into the pipeline
    output instr_t                  fetch,
    output logic                    fetch_valid,

    // occupancy of the later stages
    input  logic                    exec_valid,
    input  logic                    wb_valid,

    // register window, read port 2 and write port 1
    output logic [PTR_WIDTH-1:0]    host_rd_addr,
    input  logic [ENTRY_WIDTH-1:0]  host_rd_data,
    output logic                    host_wr_en,
    output logic [PTR_WIDTH-1:0]    host_wr_addr,
    output logic [ENTRY_WIDTH-1:0]  host_wr_data
);

    logic                   req_new;
    logic                   in_window;
    logic                   drained;
    logic                   accept;
    logic                   ack_r;
    logic                   instr_wr_r;
    logic [DATA_WIDTH-1:0]  dat_r_r;

    // a request still waiting for its ack
    assign req_new   = bus_req.cyc && bus_req.stb && !ack_r;
    assign in_window = bus_req.adr[REG_WINDOW_BIT];

    // nothing in flight, so window accesses see program order
    assign drained = !fetch_valid && !exec_valid && !wb_valid;

    assign accept = req_new && (!in_window || drained);

    // master holds adr and dat_w through the ack cycle
    assign host_rd_addr = bus_req.adr[PTR_WIDTH-1:0];
    assign host_wr_addr = bus_req.adr[PTR_WIDTH-1:0];
    assign host_wr_data = ENTRY_WIDTH'(bus_req.dat_w);

    assign bus_rsp = '{ack: ack_r, dat_r: dat_r_r};

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            ack_r       <= 1'b0;
            instr_wr_r  <= 1'b0;
            host_wr_en  <= 1'b0;
            fetch_valid <= 1'b0;
            dat_r_r     <= '0;
        end else begin
            ack_r       <= accept;
            instr_wr_r  <= accept && !in_window && bus_req.we;
            host_wr_en  <= accept && in_window && bus_req.we;
            // one-cycle valid per accepted instruction
            fetch_valid <= instr_wr_r;
            if (accept) begin
                // instruction port reads back zero
                if (in_window && !bus_req.we) begin
                    dat_r_r <= DATA_WIDTH'(host_rd_data);
                end else begin
                    dat_r_r <= '0;
                end
            end
        end
    end

    // capture at the end of the ack cycle
    always_ff @(posedge clk) begin
        if (instr_wr_r) begin
            fetch <= instr_t'(bus_req.dat_w);
        end
    end

endmodule

//--- logic/issue_stage.sv
module issue_stage
    import isa_pkg::*;
#(
    parameter int ENTRY_WIDTH = 32
) (
    input  logic                    clk,
    input  logic                    init,

    input  instr_t                  fetch,
    input  logic                    fetch_valid,

    // register file read ports 0 and 1
    output logic [PTR_WIDTH-1:0]    rs1_addr,
    output logic [PTR_WIDTH-1:0]    rs2_addr,
    input  logic [ENTRY_WIDTH-1:0]  rs1_data,
    input  logic [ENTRY_WIDTH-1:0]  rs2_data,

    // results not yet in the register file
    input  wb_bundle_t              fwd_exec,
    input  wb_bundle_t              fwd_wb,

    output exec_bundle_t            exec
);

    logic [ENTRY_WIDTH-1:0] op_a;
    logic [ENTRY_WIDTH-1:0] rs2_value;
    logic [ENTRY_WIDTH-1:0] op_b;
    exec_bundle_t           exec_next;

    // newest producer wins: execute, then writeback, then the array
    function automatic logic [ENTRY_WIDTH-1:0] forward(
        input logic [PTR_WIDTH-1:0]     src,
        input logic [ENTRY_WIDTH-1:0]   rf_value,
        input wb_bundle_t               near,
        input wb_bundle_t               far
    );
        logic [ENTRY_WIDTH-1:0] value;
        if (near.valid && near.rd == src) begin
            value = near.result[ENTRY_WIDTH-1:0];
        end else if (far.valid && far.rd == src) begin
            value = far.result[ENTRY_WIDTH-1:0];
        end else begin
            value = rf_value;
        end
        return value;
    endfunction

    assign rs1_addr = fetch.rs1;
    assign rs2_addr = fetch.rs2;

    assign op_a      = forward(fetch.rs1, rs1_data, fwd_exec, fwd_wb);
    assign rs2_value = forward(fetch.rs2, rs2_data, fwd_exec, fwd_wb);

    // load immediate takes the zero-extended imm field as operand b
    assign op_b = (fetch.op == OP_LI) ? ENTRY_WIDTH'(fetch.imm) : rs2_value;

    always_comb begin
        exec_next.valid = fetch_valid;
        exec_next.op    = fetch.op;
        exec_next.rd    = fetch.rd;
        exec_next.a     = OPERAND_WIDTH'(op_a);
        exec_next.b     = OPERAND_WIDTH'(op_b);
    end

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            exec <= '0;
        end else begin
            exec <= exec_next;
        end
    end

endmodule

//--- logic/execute_stage.sv
module execute_stage
    import isa_pkg::*;
#(
    parameter int ENTRY_WIDTH = 32
) (
    input  logic            clk,
    input  logic            init,

    input  exec_bundle_t    exec,

    // combinational result for the issue stage
    output wb_bundle_t      fwd_exec,
    // registered result, drives write port 0
    output wb_bundle_t      wb
);

    localparam int SHAMT_WIDTH = $clog2(ENTRY_WIDTH);

    logic [ENTRY_WIDTH-1:0] op_a;
    logic [ENTRY_WIDTH-1:0] op_b;
    logic [SHAMT_WIDTH-1:0] shamt;
    logic [ENTRY_WIDTH-1:0] result;

    assign op_a  = exec.a[ENTRY_WIDTH-1:0];
    assign op_b  = exec.b[ENTRY_WIDTH-1:0];
    // shift amount from the low bits of b
    assign shamt = op_b[SHAMT_WIDTH-1:0];

    always_comb begin
        case (exec.op)
            OP_ADD:  result = op_a + op_b;
            OP_SUB:  result = op_a - op_b;
            OP_AND:  result = op_a & op_b;
            OP_OR:   result = op_a | op_b;
            OP_XOR:  result = op_a ^ op_b;
            OP_SHL:  result = op_a << shamt;
            // logical, zero fill
            OP_SHR:  result = op_a >> shamt;
            OP_LI:   result = op_b;
            default: result = '0;
        endcase
    end

    always_comb begin
        fwd_exec.valid  = exec.valid;
        fwd_exec.rd     = exec.rd;
        fwd_exec.result = OPERAND_WIDTH'(result);
    end

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            wb <= '0;
        end else begin
            wb <= fwd_exec;
        end
    end

endmodule

//--- logic/alu_core.sv
module alu_core
    import isa_pkg::*;
    import bus_pkg::*;
#(
    parameter int ENTRY_WIDTH = 32
) (
    input  logic    clk,
    input  logic    init,
    input  wb_req_t bus_req,
    output wb_rsp_t bus_rsp
);

    localparam int N_RD = 3;
    localparam int N_WR = 2;

    instr_t                         fetch;
    logic                           fetch_valid;
    exec_bundle_t                   exec;
    wb_bundle_t                     fwd_exec;
    wb_bundle_t                     wb;

    logic [PTR_WIDTH-1:0]           rs1_addr;
    logic [PTR_WIDTH-1:0]           rs2_addr;
    logic [PTR_WIDTH-1:0]           host_rd_addr;
    logic [N_RD-1:0][ENTRY_WIDTH-1:0] rf_rd_data;

    logic                           host_wr_en;
    logic [PTR_WIDTH-1:0]           host_wr_addr;
    logic [ENTRY_WIDTH-1:0]         host_wr_data;

    wb_host_port #(
        .ENTRY_WIDTH (ENTRY_WIDTH)
    ) i_wb_host_port (
        .clk          (clk),
        .init         (init),
        .bus_req      (bus_req),
        .bus_rsp      (bus_rsp),
        .fetch        (fetch),
        .fetch_valid  (fetch_valid),
        .exec_valid   (exec.valid),
        .wb_valid     (wb.valid),
        .host_rd_addr (host_rd_addr),
        .host_rd_data (rf_rd_data[2]),
        .host_wr_en   (host_wr_en),
        .host_wr_addr (host_wr_addr),
        .host_wr_data (host_wr_data)
    );

    issue_stage #(
        .ENTRY_WIDTH (ENTRY_WIDTH)
    ) i_issue_stage (
        .clk         (clk),
        .init        (init),
        .fetch       (fetch),
        .fetch_valid (fetch_valid),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rf_rd_data[0]),
        .rs2_data    (rf_rd_data[1]),
        .fwd_exec    (fwd_exec),
        .fwd_wb      (wb),
        .exec        (exec)
    );

    execute_stage #(
        .ENTRY_WIDTH (ENTRY_WIDTH)
    ) i_execute_stage (
        .clk      (clk),
        .init     (init),
        .exec     (exec),
        .fwd_exec (fwd_exec),
        .wb       (wb)
    );

    // port 0 writeback, port 1 host; read port 2 is the host window
    reg_file #(
        .ENTRY_WIDTH   (ENTRY_WIDTH),
        .REG_COUNT     (REG_COUNT),
        .N_READ_PORTS  (N_RD),
        .N_WRITE_PORTS (N_WR)
    ) i_reg_file (
        .clk     (clk),
        .init    (init),
        .rd_addr ({host_rd_addr, rs2_addr, rs1_addr}),
        .rd_data (rf_rd_data),
        .wr_en   ({host_wr_en, wb.valid}),
        .wr_addr ({host_wr_addr, wb.rd}),
        .wr_data ({host_wr_data, wb.result[ENTRY_WIDTH-1:0]})
    );

endmodule

//--- testbench/alu_core_asserts.sv
module alu_core_asserts
    import bus_pkg::*;
(
    input logic    clk,
    input logic    init,
    input wb_req_t bus_req,
    input wb_rsp_t bus_rsp,
    input logic    fetch_valid,
    input logic    exec_valid,
    input logic    wb_valid,
    input logic    host_wr_en
);

    ack_single_pulse: assert property (@(posedge clk) disable iff (init)
        bus_rsp.ack |=> !bus_rsp.ack)
        else $error("ack stayed high for more than one cycle");

    ack_needs_request: assert property (@(posedge clk) disable iff (init)
        bus_rsp.ack |-> (bus_req.cyc && bus_req.stb))
        else $error("ack raised without cyc and stb");

    // writeback and host share the array
    write_ports_exclusive: assert property (@(posedge clk) disable iff (init)
        !(host_wr_en && wb_valid))
        else $error("both register file write ports enabled together");

    quiet_during_init: assert property (@(posedge clk)
        init |-> !(fetch_valid || exec_valid || wb_valid || host_wr_en || bus_rsp.ack))
        else $error("valid flag or ack high while init is high");

endmodule

bind alu_core alu_core_asserts i_alu_core_asserts (
    .clk         (clk),
    .init        (init),
    .bus_req     (bus_req),
    .bus_rsp     (bus_rsp),
    .fetch_valid (fetch_valid),
    .exec_valid  (exec.valid),
    .wb_valid    (wb.valid),
    .host_wr_en  (host_wr_en)
);

//--- testbench/tb_alu_core.sv
module tb_alu_core
    import isa_pkg::*;
    import bus_pkg::*;
();

    localparam int ENTRY_WIDTH = 32;
    localparam int N_HOST_PAIRS = 16;
    localparam int N_OP_TRIALS = 4;
    localparam int N_CHAIN = 24;
    localparam int N_BURSTS = 4;
    localparam int BURST_LEN = 6;
    localparam int N_MIX = 300;
    // reset sweep, host pairs, opcode trials, chain, bursts, mix and final sweep
    localparam int N_TRANSFERS = REG_COUNT + 2 * N_HOST_PAIRS + 8 * N_OP_TRIALS * 4
        + (N_CHAIN + 10) + N_BURSTS * (BURST_LEN + 1) + N_MIX + REG_COUNT;
    localparam int TIMEOUT_CYCLES = 40 * N_TRANSFERS;

    logic                   clk;
    logic                   init;
    wb_req_t                bus_req;
    wb_rsp_t                bus_rsp;
    logic [ENTRY_WIDTH-1:0] model [REG_COUNT];
    logic [31:0]            expected_q [$];
    int                     cycles = 0;

    alu_core #(
        .ENTRY_WIDTH (ENTRY_WIDTH)
    ) i_alu_core (
        .clk     (clk),
        .init    (init),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    always #50 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "simulation stopped on first failure");
    endtask

    // expected value of rd from the opcode rules
    function automatic logic [31:0] alu_model(input opcode_t op, input logic [31:0] a,
                                              input logic [31:0] b, input logic [12:0] imm);
        logic [31:0] r;
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SHL:  r = a << b[4:0];
            OP_SHR:  r = a >> b[4:0];
            OP_LI:   r = {19'd0, imm};
            default: r = 32'd0;
        endcase
        return r;
    endfunction

    function automatic logic [4:0] reg_pick();
        return 5'($urandom);
    endfunction

    function automatic opcode_t op_pick();
        return opcode_t'(4'($urandom % 8));
    endfunction

    // one classic cycle entered and left 5 units after a rising edge
    task automatic bus_transfer(input logic we, input logic [6:0] adr, input logic [31:0] data);
        bus_req.cyc = 1'b1;
        bus_req.stb = 1'b1;
        bus_req.we = we;
        bus_req.adr = adr;
        bus_req.dat_w = data;
        @(posedge clk);
        while (!bus_rsp.ack) begin
            @(posedge clk);
        end
        #5;
        bus_req = '0;
    endtask

    task automatic write_reg(input logic [4:0] idx, input logic [31:0] value);
        bus_transfer(1'b1, {2'b10, idx}, value);
        model[idx] = value;
    endtask

    task automatic read_reg(input logic [4:0] idx);
        expected_q.push_back(model[idx]);
        bus_transfer(1'b0, {2'b10, idx}, 32'd0);
    endtask

    task automatic issue_instr(input opcode_t op, input logic [4:0] rd, input logic [4:0] rs1,
                               input logic [4:0] rs2, input logic [12:0] imm);
        bus_transfer(1'b1, 7'd0, {op, rd, rs1, rs2, imm});
        model[rd] = alu_model(op, model[rs1], model[rs2], imm);
    endtask

    task automatic random_instr(output logic [4:0] rd);
        rd = reg_pick();
        issue_instr(op_pick(), rd, reg_pick(), reg_pick(), 13'($urandom));
    endtask

    task automatic host_write_readback();
        logic [4:0] idx [N_HOST_PAIRS];
        for (int i = 0; i < N_HOST_PAIRS; i++) begin
            // r0 holds data like any other register
            idx[i] = (i == 0) ? 5'd0 : reg_pick();
            write_reg(idx[i], $urandom);
        end
        for (int i = 0; i < N_HOST_PAIRS; i++) begin
            read_reg(idx[i]);
        end
    endtask

    task automatic opcode_sweep();
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        for (int op = 0; op < 8; op++) begin
            for (int t = 0; t < N_OP_TRIALS; t++) begin
                rd = reg_pick();
                rs1 = reg_pick();
                rs2 = reg_pick();
                write_reg(rs1, $urandom);
                write_reg(rs2, $urandom);
                issue_instr(opcode_t'(4'(op)), rd, rs1, rs2, 13'($urandom));
                read_reg(rd);
            end
        end
    endtask

    // each instruction reads the previous two destinations
    task automatic dependent_chain();
        logic [4:0] prev1;
        logic [4:0] prev2;
        logic [4:0] rd;
        prev2 = 5'd1;
        prev1 = 5'd2;
        write_reg(prev2, $urandom);
        write_reg(prev1, $urandom);
        for (int i = 0; i < N_CHAIN; i++) begin
            rd = 5'(3 + i % 6);
            issue_instr(op_pick(), rd, prev1, prev2, 13'($urandom));
            prev2 = prev1;
            prev1 = rd;
        end
        for (int r = 1; r <= 8; r++) begin
            read_reg(5'(r));
        end
    endtask

    task automatic read_after_burst();
        logic [4:0] rd;
        for (int b = 0; b < N_BURSTS; b++) begin
            for (int i = 0; i < BURST_LEN; i++) begin
                random_instr(rd);
            end
            read_reg(rd);
        end
    endtask

    task automatic mixed_traffic();
        logic [4:0] rd;
        for (int i = 0; i < N_MIX; i++) begin
            case ($urandom % 4)
                0, 1:    random_instr(rd);
                2:       write_reg(reg_pick(), $urandom);
                default: read_reg(reg_pick());
            endcase
        end
        for (int r = 0; r < REG_COUNT; r++) begin
            read_reg(5'(r));
        end
    endtask

    // compares every register-window read at its ack
    always @(posedge clk) begin : compare_reads
        logic [31:0] expected;
        if (!init && bus_rsp.ack && !bus_req.we && bus_req.adr[REG_WINDOW_BIT]) begin
            assert (expected_q.size() != 0)
                else report_failure("register read acknowledged with no read outstanding");
            if (expected_q.size() != 0) begin
                expected = expected_q.pop_front();
                assert (bus_rsp.dat_r == expected)
                    else report_failure($sformatf(
                        "error: bus_rsp.dat_r expected 0x%08h actual 0x%08h",
                        expected, bus_rsp.dat_r));
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        void'($urandom(67));
        clk = 1'b0;
        init = 1'b0;
        bus_req = '0;
        for (int r = 0; r < REG_COUNT; r++) begin
            model[r] = '0;
        end
        #1 init = 1'b1;
        repeat (3) @(posedge clk);
        #5 init = 1'b0;

        for (int r = 0; r < REG_COUNT; r++) begin
            read_reg(5'(r));
        end
        host_write_readback();
        opcode_sweep();
        dependent_chain();
        read_after_burst();
        mixed_traffic();

        if (expected_q.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            report_failure("some register reads were never acknowledged");
        end
    end

endmodule

//--- files.f
logic/isa_pkg.sv
logic/bus_pkg.sv
logic/reg_file.sv
logic/wb_host_port.sv
logic/issue_stage.sv
logic/execute_stage.sv
logic/alu_core.sv
testbench/alu_core_asserts.sv
testbench/tb_alu_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the alu_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_alu_core -f files.f -o tb_alu_core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_alu_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "tests failed" "$LOG"; then
    exit 1
fi

if ! grep -qx "all tests passed" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0
